// ==== irq_pkg.sv ====
////////////////////////////////////////////////////////////
// interrupt line definitions
// line count, group sizing of the priority tree and the
// trap cause word with its two views
////////////////////////////////////////////////////////////
`default_nettype none

package irq_pkg;

  // external interrupt lines, split into equal groups
  localparam int unsigned num_irq_lines  = 32;
  localparam int unsigned irq_group_size = 8;
  localparam int unsigned num_irq_groups = num_irq_lines / irq_group_size;

  // index widths: full line index and index inside one group
  localparam int unsigned irq_id_w     = 5;
  localparam int unsigned irq_grp_id_w = 3;

  // decoded view of the cause word
  typedef struct packed {
    logic                irq;
    logic [irq_id_w-1:0] id;
  } irq_cause_fields_t;

  // raw view goes straight to the trap cause CSR
  typedef union packed {
    logic [irq_id_w:0] raw;
    irq_cause_fields_t fields;
  } irq_cause_u;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
////////////////////////////////////////////////////////////
// controller definitions
// FSM state encoding, fetch address select and fixed causes
////////////////////////////////////////////////////////////
`default_nettype none

package ctrl_pkg;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    WAIT_SLEEP,
    SLEEP,
    IRQ_TAKEN
  } ctrl_state_e;

  // fetch address select, only looked at while pc_set is high
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // NMI cause: interrupt flag set, index 31
  localparam logic [5:0] cause_nmi = 6'h3f;

endpackage

`default_nettype wire

// ==== irq_qualify.sv ====
////////////////////////////////////////////////////////////
// interrupt line qualify stage
// masks the lines with their enables and registers them,
// the register freezes while an acknowledge is open
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module irq_qualify import irq_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic [num_irq_lines-1:0] irq_lines_i,
  input  wire logic [num_irq_lines-1:0] irq_en_i,
  input  wire logic                     hold_i,
  output logic      [num_irq_lines-1:0] pend_q_o
);

  // masked lines before the register
  logic [num_irq_lines-1:0] pend_d;
  logic [num_irq_lines-1:0] pend_q;

  // per-line enable, mie is applied later in cause select
  assign pend_d = irq_lines_i & irq_en_i;

  // hold keeps index and cause consistent with the ack in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q <= '0;
    end else if (!hold_i) begin
      pend_q <= pend_d;
    end
  end

  assign pend_q_o = pend_q;

endmodule

`default_nettype wire

// ==== irq_group_prio.sv ====
////////////////////////////////////////////////////////////
// group priority encoder
// highest pending line among eight, highest index wins
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module irq_group_prio import irq_pkg::*; (
  input  wire logic [irq_group_size-1:0] lines_i,
  output logic                           valid_o,
  output logic      [irq_grp_id_w-1:0]   id_o
);

  // any line in this group
  assign valid_o = |lines_i;

  // scan upward so the last hit is the highest index
  always_comb begin
    id_o = '0;
    for (int unsigned i = 0; i < irq_group_size; i++) begin
      if (lines_i[i]) begin
        id_o = irq_grp_id_w'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== irq_cause_select.sv ====
////////////////////////////////////////////////////////////
// interrupt cause select
// picks the highest group, applies NMI priority and the
// mie / NMI-mode gating, and forms the trap cause word
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module irq_cause_select import irq_pkg::*, ctrl_pkg::*; (
  input  wire logic [num_irq_groups-1:0]                   grp_valid_i,
  input  wire logic [num_irq_groups-1:0][irq_grp_id_w-1:0] grp_id_i,
  input  wire logic                                        irq_nm_i,
  input  wire logic                                        mie_i,
  input  wire logic                                        nmi_mode_i,
  output logic                                             irq_pending_o,
  output logic                                             is_ext_o,
  output irq_cause_u                                       cause_o
);

  localparam int unsigned grp_sel_w = irq_id_w - irq_grp_id_w;

  logic                    ext_pending;
  logic [grp_sel_w-1:0]    sel_grp;
  logic [irq_grp_id_w-1:0] sel_local;

  // highest valid group, later groups override earlier ones
  always_comb begin
    sel_grp   = '0;
    sel_local = '0;
    for (int unsigned g = 0; g < num_irq_groups; g++) begin
      if (grp_valid_i[g]) begin
        sel_grp   = grp_sel_w'(g);
        sel_local = grp_id_i[g];
      end
    end
  end

  // external lines only count with mie set
  assign ext_pending = mie_i & (|grp_valid_i);

  // nothing is taken inside the NMI handler
  assign irq_pending_o = ~nmi_mode_i & (irq_nm_i | ext_pending);

  // NMI wins over every external line
  assign is_ext_o = ~irq_nm_i & ext_pending;

  always_comb begin
    if (irq_nm_i) begin
      cause_o.raw = cause_nmi;
    end else begin
      // group number forms the upper index bits
      cause_o.fields.irq = 1'b1;
      cause_o.fields.id  = {sel_grp, sel_local};
    end
  end

endmodule

`default_nettype wire

// ==== irq_ack_port.sv ====
////////////////////////////////////////////////////////////
// interrupt acknowledge port
// four-phase req/ack of the taken external line towards
// the interrupt controller
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module irq_ack_port import irq_pkg::*; (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                take_i,
  input  wire logic [irq_id_w-1:0] id_i,
  input  wire logic                ack_i,
  output logic                     ack_req_o,
  output logic      [irq_id_w-1:0] ack_id_o,
  output logic                     busy_o
);

  typedef enum logic [1:0] {
    ACK_IDLE,
    ACK_REQ,
    ACK_REL
  } ack_state_e;

  ack_state_e ack_cs, ack_ns;
  logic [irq_id_w-1:0] id_q;

  always_comb begin
    ack_ns = ack_cs;
    unique case (ack_cs)
      ACK_IDLE: if (take_i) ack_ns = ACK_REQ;
      // req held until the controller answers
      ACK_REQ:  if (ack_i) ack_ns = ACK_REL;
      // req is down, wait for ack to follow
      ACK_REL:  if (!ack_i) ack_ns = ACK_IDLE;
      default:  ack_ns = ACK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_cs <= ACK_IDLE;
    end else begin
      ack_cs <= ack_ns;
    end
  end

  // index captured at the take, stable for the whole handshake
  always_ff @(posedge clk_i) begin
    if (take_i && (ack_cs == ACK_IDLE)) begin
      id_q <= id_i;
    end
  end

  assign ack_req_o = (ack_cs == ACK_REQ);
  assign ack_id_o  = id_q;
  // busy already in the take cycle so the pending lines freeze at once
  assign busy_o    = take_i | (ack_cs != ACK_IDLE);

endmodule

`default_nettype wire

// ==== ctrl_fsm.sv ====
////////////////////////////////////////////////////////////
// controller FSM
// boot redirect, decode loop, sleep, interrupt taking and
// MRET, plus NMI mode and the stall outputs
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_fsm import irq_pkg::*, ctrl_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire logic        instr_valid_i,
  input  wire logic        mret_insn_i,
  input  wire logic        wfi_insn_i,
  input  wire logic        stall_i,
  input  wire logic        irq_pending_i,
  input  wire logic        is_ext_i,
  input  wire irq_cause_u  cause_i,
  input  wire logic        ack_busy_i,
  output logic             pc_set_o,
  output pc_sel_e          pc_sel_o,
  output logic             csr_save_cause_o,
  output logic [5:0]       cause_o,
  output logic             take_ext_o,
  output logic             nmi_mode_o,
  output logic             busy_o,
  output logic             id_in_ready_o
);

  ctrl_state_e ctrl_cs, ctrl_ns;

  logic       nmi_mode_q, nmi_mode_d;
  logic       is_ext_q;
  logic       flush_mret_q;
  logic       ack_busy_q;
  logic [5:0] cause_q;
  logic       halt_id;
  logic       ext_blocked;
  logic       take_irq;

  ////////////////////////////////////////////////////////////
  // take condition
  ////////////////////////////////////////////////////////////

  // pend_q refreshes one cycle after the freeze lifts, so the
  // old ack line stays blocked for that extra cycle
  assign ext_blocked = ack_busy_i | ack_busy_q;
  assign take_irq    = irq_pending_i & ~(is_ext_i & ext_blocked);

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_ns          = ctrl_cs;
    nmi_mode_d       = nmi_mode_q;
    pc_set_o         = 1'b0;
    pc_sel_o         = PC_BOOT;
    csr_save_cause_o = 1'b0;
    busy_o           = 1'b1;
    halt_id          = 1'b0;

    unique case (ctrl_cs)
      RESET: begin
        // boot address goes out straight from reset
        pc_set_o = 1'b1;
        halt_id  = 1'b1;
        ctrl_ns  = BOOT_SET;
      end
      BOOT_SET: begin
        pc_set_o = 1'b1;
        halt_id  = 1'b1;
        ctrl_ns  = FIRST_FETCH;
      end
      FIRST_FETCH: begin
        if (!stall_i) ctrl_ns = DECODE;
      end
      DECODE: begin
        if (instr_valid_i && !stall_i) begin
          // special instructions retire before an interrupt is taken
          if (mret_insn_i || wfi_insn_i) begin
            halt_id = 1'b1;
            ctrl_ns = FLUSH;
          end else if (take_irq) begin
            halt_id = 1'b1;
            ctrl_ns = IRQ_TAKEN;
          end
        end
      end
      FLUSH: begin
        halt_id = 1'b1;
        if (flush_mret_q) begin
          // return from handler, also ends the NMI handler
          pc_set_o   = 1'b1;
          pc_sel_o   = PC_ERET;
          nmi_mode_d = 1'b0;
          ctrl_ns    = DECODE;
        end else begin
          ctrl_ns = WAIT_SLEEP;
        end
      end
      WAIT_SLEEP: begin
        busy_o  = 1'b0;
        halt_id = 1'b1;
        ctrl_ns = SLEEP;
      end
      SLEEP: begin
        halt_id = 1'b1;
        // wake on anything that could be taken
        if (irq_pending_i) begin
          ctrl_ns = FIRST_FETCH;
        end else begin
          busy_o = 1'b0;
        end
      end
      IRQ_TAKEN: begin
        pc_set_o         = 1'b1;
        pc_sel_o         = PC_EXC;
        csr_save_cause_o = 1'b1;
        halt_id          = 1'b1;
        // an NMI take enters NMI mode
        if (!is_ext_q) nmi_mode_d = 1'b1;
        ctrl_ns = DECODE;
      end
      default: begin
        halt_id = 1'b1;
        ctrl_ns = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_cs      <= RESET;
      nmi_mode_q   <= 1'b0;
      is_ext_q     <= 1'b0;
      flush_mret_q <= 1'b0;
      ack_busy_q   <= 1'b0;
    end else begin
      ctrl_cs    <= ctrl_ns;
      nmi_mode_q <= nmi_mode_d;
      ack_busy_q <= ack_busy_i;
      if (ctrl_ns == IRQ_TAKEN) is_ext_q <= is_ext_i;
      // remember whether FLUSH is serving MRET or WFI
      if ((ctrl_cs == DECODE) && (ctrl_ns == FLUSH)) flush_mret_q <= mret_insn_i;
    end
  end

  // cause frozen at the decision, valid throughout IRQ_TAKEN
  always_ff @(posedge clk_i) begin
    if (ctrl_ns == IRQ_TAKEN) cause_q <= cause_i.raw;
  end

  assign cause_o       = cause_q;
  assign take_ext_o    = (ctrl_cs == IRQ_TAKEN) & is_ext_q;
  assign nmi_mode_o    = nmi_mode_q;
  assign id_in_ready_o = ~stall_i & ~halt_id;

endmodule

`default_nettype wire

// ==== ctrl_top.sv ====
////////////////////////////////////////////////////////////
// controller top level
// interrupt qualify, priority tree, cause select, ack port
// and the controller FSM
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_top import irq_pkg::*, ctrl_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // interrupt lines and masks
  input  wire logic [num_irq_lines-1:0] irq_lines_i,
  input  wire logic [num_irq_lines-1:0] irq_en_i,
  input  wire logic                     mie_i,
  input  wire logic                     irq_nm_i,
  // instruction side
  input  wire logic                     instr_valid_i,
  input  wire logic                     mret_insn_i,
  input  wire logic                     wfi_insn_i,
  input  wire logic                     stall_i,
  // fetch redirect
  output logic                          pc_set_o,
  output pc_sel_e                       pc_sel_o,
  // trap outputs
  output logic                          csr_save_cause_o,
  output logic      [irq_id_w:0]        cause_o,
  output logic                          nmi_mode_o,
  output logic                          busy_o,
  output logic                          id_in_ready_o,
  // acknowledge handshake
  output logic                          ack_req_o,
  output logic      [irq_id_w-1:0]      ack_id_o,
  input  wire logic                     ack_i
);

  logic [num_irq_lines-1:0]                    pend_q;
  logic [num_irq_groups-1:0]                   grp_valid;
  logic [num_irq_groups-1:0][irq_grp_id_w-1:0] grp_id;
  logic                                        irq_pending;
  logic                                        take_is_ext;
  irq_cause_u                                  cause;
  logic                                        take_ext;
  logic                                        ack_busy;

  irq_qualify u_qualify (
    .clk_i, .rst_ni, .irq_lines_i, .irq_en_i,
    .hold_i(ack_busy), .pend_q_o(pend_q)
  );

  // one encoder per group of eight lines
  for (genvar g = 0; g < num_irq_groups; g++) begin : g_grp
    irq_group_prio u_grp_prio (
      .lines_i(pend_q[g*irq_group_size +: irq_group_size]),
      .valid_o(grp_valid[g]), .id_o(grp_id[g])
    );
  end

  irq_cause_select u_cause_sel (
    .grp_valid_i(grp_valid), .grp_id_i(grp_id), .irq_nm_i, .mie_i,
    .nmi_mode_i(nmi_mode_o), .irq_pending_o(irq_pending),
    .is_ext_o(take_is_ext), .cause_o(cause)
  );

  // low cause bits carry the taken line index
  irq_ack_port u_ack_port (
    .clk_i, .rst_ni, .take_i(take_ext), .id_i(cause_o[irq_id_w-1:0]),
    .ack_i, .ack_req_o, .ack_id_o, .busy_o(ack_busy)
  );

  ctrl_fsm u_fsm (
    .clk_i, .rst_ni, .instr_valid_i, .mret_insn_i, .wfi_insn_i, .stall_i,
    .irq_pending_i(irq_pending), .is_ext_i(take_is_ext), .cause_i(cause),
    .ack_busy_i(ack_busy), .pc_set_o, .pc_sel_o, .csr_save_cause_o, .cause_o,
    .take_ext_o(take_ext), .nmi_mode_o, .busy_o, .id_in_ready_o
  );

endmodule

`default_nettype wire

// ==== ctrl_checker.sv ====
////////////////////////////////////////////////////////////
// controller and acknowledge checker
// concurrent rules on FSM state, trap save and the
// four-phase acknowledge handshake
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ctrl_checker import ctrl_pkg::*; (
  input wire logic       clk_i,
  input wire logic       rst_ni,
  input wire logic [3:0] state_i,
  input wire logic       pc_set_i,
  input wire logic       csr_save_cause_i,
  input wire logic       ack_req_i,
  input wire logic       ack_i,
  input wire logic [4:0] ack_id_i
);

  // failed assertions, collected by the testbench at the end
  int assert_fails = 0;

  // only the eight encoded states may show up
  a_legal_state: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, WAIT_SLEEP, SLEEP, IRQ_TAKEN})
    else begin
      $error("controller state is not a legal state");
      assert_fails++;
    end

  // a trap redirect always saves the cause
  a_take_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == IRQ_TAKEN && pc_set_i) |-> csr_save_cause_i)
    else begin
      $error("trap redirect without cause save");
      assert_fails++;
    end

  // new request only once the previous ack has dropped
  a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(ack_req_i) |-> !ack_i)
    else begin
      $error("ack request rose while ack was still high");
      assert_fails++;
    end

  // index must not move while the request is up
  a_ack_id_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_req_i && $past(ack_req_i)) |-> $stable(ack_id_i))
    else begin
      $error("ack index changed during the request");
      assert_fails++;
    end

endmodule

// FSM side, handshake inputs tied off
bind ctrl_fsm ctrl_checker u_ctrl_chk (
  .clk_i, .rst_ni, .state_i(ctrl_cs), .pc_set_i(pc_set_o),
  .csr_save_cause_i(csr_save_cause_o), .ack_req_i(1'b0), .ack_i(1'b0), .ack_id_i(5'd0)
);

// acknowledge side, controller inputs tied to a quiet legal state
bind irq_ack_port ctrl_checker u_ack_chk (
  .clk_i, .rst_ni, .state_i(ctrl_pkg::DECODE), .pc_set_i(1'b0),
  .csr_save_cause_i(1'b0), .ack_req_i(ack_req_o), .ack_i, .ack_id_i(ack_id_o)
);

`default_nettype wire

// ==== tb_ctrl_top.sv ====
////////////////////////////////////////////////////////////
// testbench for the interrupt controller top level
// boot, interrupt takes, acknowledge, NMI, MRET, WFI and
// stall from a stimulus table with a reference model
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top import irq_pkg::*, ctrl_pkg::*; ();

  localparam int reset_cycles = 10;
  localparam int num_rows     = 17;
  localparam int cycle_limit  = reset_cycles + num_rows * 40;
  localparam int take_window  = 10;
  // instruction kinds in the table
  localparam int kind_none = 0;
  localparam int kind_mret = 1;
  localparam int kind_wfi  = 2;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic [31:0] irq_lines_i;
  logic [31:0] irq_en_i;
  logic        mie_i;
  logic        irq_nm_i;
  logic        instr_valid_i;
  logic        mret_insn_i;
  logic        wfi_insn_i;
  logic        stall_i;
  logic        pc_set_o;
  pc_sel_e     pc_sel_o;
  logic        csr_save_cause_o;
  logic [5:0]  cause_o;
  logic        nmi_mode_o;
  logic        busy_o;
  logic        id_in_ready_o;
  logic        ack_req_o;
  logic [4:0]  ack_id_o;
  logic        ack_i = 1'b0;

  // stimulus table, one entry per row
  logic [31:0] row_lines [num_rows];
  logic [31:0] row_en    [num_rows];
  logic        row_mie   [num_rows];
  logic        row_nmi   [num_rows];
  int          row_stall [num_rows];
  int          row_kind  [num_rows];
  logic        row_take  [num_rows];
  logic [5:0]  row_cause [num_rows];

  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int ack_dly = 0;

  ctrl_top uut (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // interrupt controller side of the acknowledge
  ////////////////////////////////////////////////////////////

  // ack follows each req edge two cycles later
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      ack_i   <= 1'b0;
      ack_dly <= 0;
    end else if (ack_req_o != ack_i) begin
      if (ack_dly == 2) begin
        ack_i   <= ack_req_o;
        ack_dly <= 0;
      end else begin
        ack_dly <= ack_dly + 1;
      end
    end else begin
      ack_dly <= 0;
    end
  end

  // run limit from the table length
  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      errors++;
      finish_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // highest enabled line with the flag set, NMI overrides
  function automatic logic [5:0] model_cause(input logic [31:0] lines, input logic [31:0] en,
                                             input logic nmi);
    irq_cause_u  c;
    logic [31:0] masked;
    masked = lines & en;
    c.raw  = '0;
    if (nmi) begin
      c.raw = cause_nmi;
    end else begin
      for (int k = num_irq_lines - 1; k >= 0; k--) begin
        if (masked[k] && !c.fields.irq) begin
          c.fields.irq = 1'b1;
          c.fields.id  = k[4:0];
        end
      end
    end
    return c.raw;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_event(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      $display("ERROR: %s", what);
      errors++;
    end
  endtask

  task automatic set_row(input int idx, input logic [31:0] lines, input logic [31:0] en,
                         input logic mie, input logic nmi, input int stall, input int kind,
                         input logic take, input logic [5:0] cause);
    row_lines[idx] = lines;
    row_en[idx]    = en;
    row_mie[idx]   = mie;
    row_nmi[idx]   = nmi;
    row_stall[idx] = stall;
    row_kind[idx]  = kind;
    row_take[idx]  = take;
    row_cause[idx] = cause;
  endtask

  task automatic load_table();
    logic [31:0] seed;
    logic [31:0] lines;
    logic [31:0] en;
    seed = 32'h1effb902;
    // idx  lines          enables        mie  nmi  stall kind       take cause
    set_row(0,  32'h0000_0012, 32'hffff_ffff, 1, 0, 0, kind_none, 1, 6'h24);
    set_row(1,  32'h0000_8100, 32'h0000_00ff, 1, 0, 0, kind_none, 0, 6'h00);
    set_row(2,  32'h00f0_0000, 32'hffff_ffff, 0, 0, 0, kind_none, 0, 6'h00);
    set_row(3,  32'h0a00_0401, 32'h0200_0401, 1, 0, 0, kind_none, 1, 6'h39);
    set_row(4,  32'h8000_0000, 32'hffff_ffff, 1, 0, 0, kind_none, 1, 6'h3f);
    set_row(5,  32'h0000_0f00, 32'hffff_ffff, 1, 1, 0, kind_none, 1, cause_nmi);
    // inside the NMI handler nothing is taken
    set_row(6,  32'h0000_0040, 32'hffff_ffff, 1, 0, 0, kind_none, 0, 6'h00);
    set_row(7,  32'h0000_0000, 32'h0000_0000, 1, 1, 0, kind_none, 0, 6'h00);
    set_row(8,  32'h0000_0000, 32'h0000_0000, 0, 0, 0, kind_mret, 0, 6'h00);
    set_row(9,  32'h0001_0000, 32'hffff_ffff, 1, 0, 4, kind_none, 1, 6'h30);
    set_row(10, 32'h0000_0008, 32'hffff_ffff, 1, 0, 0, kind_wfi,  1, 6'h23);
    set_row(11, 32'h0100_0000, 32'hffff_ffff, 1, 1, 3, kind_none, 1, cause_nmi);
    set_row(12, 32'h0000_0000, 32'h0000_0000, 0, 0, 0, kind_mret, 0, 6'h00);
    // random lines and enables, expected values from the model
    for (int r = 13; r < num_rows; r++) begin
      seed  = xorshift32(seed);
      lines = seed;
      seed  = xorshift32(seed);
      en    = seed;
      set_row(r, lines, en, 1, 0, 0, kind_none, |(lines & en), model_cause(lines, en, 1'b0));
    end
  endtask

  task automatic wait_ack_signal(input logic on_req, input logic level, input string what);
    int n;
    n = 0;
    while (((on_req ? ack_req_o : ack_i) !== level) && n < 10) begin
      @(negedge clk_i);
      n++;
    end
    check_event((on_req ? ack_req_o : ack_i) === level, what);
  endtask

  // full four-phase cycle for one external take
  task automatic check_handshake(input logic [4:0] exp_id);
    wait_ack_signal(1'b1, 1'b1, "acknowledge request did not rise");
    check_value("ack_id_o", ack_id_o, exp_id);
    wait_ack_signal(1'b0, 1'b1, "acknowledge did not rise");
    wait_ack_signal(1'b1, 1'b0, "acknowledge request did not drop");
    wait_ack_signal(1'b0, 1'b0, "acknowledge did not drop");
  endtask

  // boot redirect lasts two cycles, trap outputs quiet
  task automatic check_boot();
    int boot_cycles;
    boot_cycles = 0;
    while (pc_set_o && boot_cycles < 8) begin
      check_value("pc_sel_o", pc_sel_o, PC_BOOT);
      check_value("ack_req_o", ack_req_o, 1'b0);
      check_value("csr_save_cause_o", csr_save_cause_o, 1'b0);
      check_value("nmi_mode_o", nmi_mode_o, 1'b0);
      check_value("id_in_ready_o", id_in_ready_o, 1'b0);
      boot_cycles++;
      @(negedge clk_i);
    end
    check_value("pc_set_o cycles", boot_cycles, 2);
  endtask

  task automatic run_row(input int i);
    logic       taken;
    int         n;
    irq_cause_u exp_cause;
    taken         = 1'b0;
    exp_cause.raw = row_cause[i];
    if (row_kind[i] == kind_mret) begin
      mret_insn_i = 1'b1;
      n = 0;
      while (!(pc_set_o && pc_sel_o == PC_ERET) && n < 8) begin
        @(negedge clk_i);
        n++;
      end
      check_event(pc_set_o && pc_sel_o == PC_ERET, "MRET gave no return redirect");
      mret_insn_i = 1'b0;
      @(negedge clk_i);
      check_value("nmi_mode_o", nmi_mode_o, 1'b0);
    end
    if (row_kind[i] == kind_wfi) begin
      wfi_insn_i = 1'b1;
      n = 0;
      while (busy_o && n < 8) begin
        @(negedge clk_i);
        n++;
      end
      check_event(!busy_o, "core did not go to sleep after WFI");
      wfi_insn_i = 1'b0;
      // stays asleep with nothing pending
      repeat (3) begin
        @(negedge clk_i);
        check_value("busy_o", busy_o, 1'b0);
      end
    end
    irq_lines_i = row_lines[i];
    irq_en_i    = row_en[i];
    mie_i       = row_mie[i];
    irq_nm_i    = row_nmi[i];
    stall_i     = (row_stall[i] > 0);
    if (row_kind[i] == kind_wfi) begin
      n = 0;
      while (!busy_o && n < 8) begin
        @(negedge clk_i);
        n++;
      end
      check_event(busy_o, "core did not wake from sleep");
    end
    for (n = 0; n < row_stall[i]; n++) begin
      @(negedge clk_i);
      check_event(!(pc_set_o && pc_sel_o == PC_EXC), "interrupt taken during a stall");
      check_value("id_in_ready_o", id_in_ready_o, 1'b0);
    end
    stall_i = 1'b0;
    n = 0;
    while (!taken && n < take_window) begin
      @(negedge clk_i);
      taken = pc_set_o && (pc_sel_o == PC_EXC);
      n++;
    end
    if (row_take[i]) begin
      check_event(taken, "expected interrupt was not taken");
    end else begin
      check_event(!taken, "interrupt taken where none was expected");
      // idle decode accepts the next instruction
      check_value("id_in_ready_o", id_in_ready_o, 1'b1);
    end
    if (taken) begin
      check_value("cause_o", cause_o, row_cause[i]);
      check_value("csr_save_cause_o", csr_save_cause_o, 1'b1);
    end
    irq_lines_i = '0;
    irq_nm_i    = 1'b0;
    if (taken) begin
      @(negedge clk_i);
      check_value("nmi_mode_o", nmi_mode_o, row_nmi[i]);
      if (!row_nmi[i]) check_handshake(exp_cause.fields.id);
    end
    // let the frozen lines refresh before the next row
    repeat (3) @(negedge clk_i);
  endtask

  task automatic finish_run();
    int chk_fails;
    chk_fails = uut.u_fsm.u_ctrl_chk.assert_fails + uut.u_ack_port.u_ack_chk.assert_fails;
    $display("checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, chk_fails);
    if (errors == 0 && chk_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_ni        = 1'b0;
    irq_lines_i   = '0;
    irq_en_i      = '0;
    mie_i         = 1'b0;
    irq_nm_i      = 1'b0;
    instr_valid_i = 1'b0;
    mret_insn_i   = 1'b0;
    wfi_insn_i    = 1'b0;
    stall_i       = 1'b0;
    load_table();
    repeat (reset_cycles) @(negedge clk_i);
    rst_ni = 1'b1;
    check_boot();
    // FIRST_FETCH now, decode from the next cycle
    instr_valid_i = 1'b1;
    @(negedge clk_i);
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    finish_run();
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
irq_pkg.sv
ctrl_pkg.sv
irq_qualify.sv
irq_group_prio.sv
irq_cause_select.sv
irq_ack_port.sv
ctrl_fsm.sv
ctrl_top.sv
ctrl_checker.sv
tb_ctrl_top.sv
